//--- sha512_pad_macros.svh
// --------------------------------------------------
// Sizing constants for the SHA-512 block front end
// Message lengths are byte counts that fit in 32 bits
// --------------------------------------------------
`ifndef SHA512_PAD_MACROS_SVH
`define SHA512_PAD_MACROS_SVH

`default_nettype none

// Input word and message block geometry
`define SHA_WORD_W       32
`define SHA_BLOCK_W      1024
`define SHA_BLOCK_WORDS  32
`define SHA_BLOCK_BYTES  128

// Big-endian bit length at the tail of the final block
`define SHA_LEN_FIELD_W  128
// Data bytes in the last block from which the length no longer fits
`define SHA_PAD_LIMIT    112

// Queue depths, the input depth is also the upstream credit count after reset
`define SHA_IN_DEPTH     4
`define SHA_OUT_DEPTH    2
`define SHA_CREDIT_W     3

`default_nettype wire
`endif

//--- sha512_pad_pkg.sv
// --------------------------------------------------
// Shared types for the SHA-512 block front end
// Blocks are big-endian with word 0 in the top bits
// --------------------------------------------------
`include "sha512_pad_macros.svh"
`default_nettype none

package sha512_pad_pkg;

  // One input word, message byte 0 sits in bits 31:24
  typedef logic [`SHA_WORD_W-1:0] word_t;

  // Packed so that word 0 lands in the most significant bits
  typedef word_t [0:`SHA_BLOCK_WORDS-1] block_t;

  // Block as it travels through the output queue
  typedef struct packed {
    block_t data;
    logic   first;
    logic   last;
  } blk_msg_t;

  // Block sequencing states
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_FILL = 2'b01,
    ST_PAD0 = 2'b10,
    ST_PAD1 = 2'b11
  } build_state_e;

  // Data-pad keeps the tail data, length-only builds the extra block
  typedef enum logic {
    PAD_DATA     = 1'b0,
    PAD_LEN_ONLY = 1'b1
  } pad_op_e;

endpackage

`default_nettype wire

//--- credit_fifo.sv
// --------------------------------------------------
// Receiver queue that hands back one credit per pop
// Push while full and pop while empty are ignored
// --------------------------------------------------
`timescale 1ns/1ps
`include "sha512_pad_macros.svh"
`default_nettype none

module credit_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = `SHA_IN_DEPTH
) (
  input  logic     clk,
  input  logic     rst_b,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     not_empty,
  output logic     full,
  output logic     credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push & ~full;
  assign do_pop  = pop & not_empty;

  // Head entry is read straight from storage, so a push shows up one cycle later
  assign pop_data  = mem[rd_ptr];
  assign not_empty = (count != '0);
  assign full      = (count == (PTR_W+1)'(DEPTH));

  // Every accepted pop frees a slot and returns it to the sender
  assign credit = do_pop;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap explicitly so any depth works
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

//--- sha512_pad_logic.sv
// --------------------------------------------------
// Combinational SHA-512 padding of one block
// bytes_in_block is only meaningful for data-pad
// --------------------------------------------------
`timescale 1ns/1ps
`include "sha512_pad_macros.svh"
`default_nettype none

module sha512_pad_logic (
  input  sha512_pad_pkg::pad_op_e op,
  input  logic [6:0]              bytes_in_block,
  input  logic [31:0]             msg_len,
  input  sha512_pad_pkg::block_t  block_in,
  output sha512_pad_pkg::block_t  block_out,
  output logic                    need_extra
);

  localparam int LEN_BYTES = `SHA_LEN_FIELD_W / 8;
  localparam int LEN_FIRST = `SHA_BLOCK_BYTES - LEN_BYTES;
  localparam int SHIFT_W   = $clog2(`SHA_BLOCK_W) + 1;

  logic [SHIFT_W-1:0]              keep_shift;
  logic [`SHA_BLOCK_W-1:0]         keep_mask;
  logic [`SHA_LEN_FIELD_W-1:0]     bit_len;
  logic [0:`SHA_BLOCK_BYTES-1][7:0] pad_bytes;

  // The 0x80 byte and 16 length bytes must fit after the data
  assign need_extra = (op == sha512_pad_pkg::PAD_DATA) &&
                      (bytes_in_block >= 7'(`SHA_PAD_LIMIT));

  // Mask keeps the leading data bytes, an empty block keeps nothing
  assign keep_shift = SHIFT_W'(`SHA_BLOCK_W) - {bytes_in_block, 3'b000};
  assign keep_mask  = {`SHA_BLOCK_W{1'b1}} << keep_shift;

  // Message length in bits, big-endian in the last 16 bytes
  assign bit_len = {{(`SHA_LEN_FIELD_W-35){1'b0}}, msg_len, 3'b000};

  // ----------------------------------------------
  // Block assembly
  // ----------------------------------------------
  always_comb begin
    if (op == sha512_pad_pkg::PAD_LEN_ONLY) begin
      // Extra block carries nothing but zeros and the length
      pad_bytes = '0;
    end else begin
      pad_bytes = block_in & keep_mask;
      // Bytes past the length in the final word are dropped by the mask
      pad_bytes[bytes_in_block] = 8'h80;
    end

    // When an extra block follows, the length goes there instead
    if (!need_extra) begin
      pad_bytes[LEN_FIRST:`SHA_BLOCK_BYTES-1] = bit_len;
    end

    block_out = pad_bytes;
  end

endmodule

`default_nettype wire

//--- sha512_block_builder.sv
// --------------------------------------------------
// Collects words into 1024-bit blocks and pads the tail
// msg_start is honoured only while busy is low
// --------------------------------------------------
`timescale 1ns/1ps
`include "sha512_pad_macros.svh"
`default_nettype none

module sha512_block_builder (
  input  logic                     clk,
  input  logic                     rst_b,
  input  logic                     msg_start,
  input  logic [31:0]              msg_len,
  output logic                     busy,
  input  logic                     word_avail,
  input  sha512_pad_pkg::word_t    word_in,
  output logic                     word_pop,
  input  logic                     out_full,
  output logic                     out_push,
  output sha512_pad_pkg::blk_msg_t out_msg
);

  localparam int PTR_W  = $clog2(`SHA_BLOCK_WORDS);
  localparam int BYTE_W = $clog2(`SHA_BLOCK_BYTES);

  sha512_pad_pkg::build_state_e state;
  sha512_pad_pkg::build_state_e state_nxt;
  sha512_pad_pkg::block_t       block_reg;
  sha512_pad_pkg::block_t       pad_block;
  sha512_pad_pkg::pad_op_e      pad_op;

  logic [31:0]    len_q;
  logic [30:0]    words_left;
  logic [30:0]    msg_words;
  logic [PTR_W:0] word_ptr;
  logic           first_q;
  logic           block_full;
  logic           last_pop;
  logic           tail_bytes;
  logic           need_extra;

  // Word count of the message, rounded up to whole words
  assign msg_words = {1'b0, msg_len[31:2]} + {30'd0, |msg_len[1:0]};

  // Top pointer bit set means all 32 words are in
  assign block_full = word_ptr[PTR_W];
  // A partial final block is padded in place rather than pushed raw
  assign tail_bytes = |len_q[BYTE_W-1:0];

  assign word_pop = (state == sha512_pad_pkg::ST_FILL) & ~block_full &
                    (words_left != '0) & word_avail;
  assign last_pop = word_pop & (words_left == 31'd1);

  assign busy = (state != sha512_pad_pkg::ST_IDLE);

  // PAD1 reuses the same padding logic in length-only mode
  assign pad_op = (state == sha512_pad_pkg::ST_PAD1) ? sha512_pad_pkg::PAD_LEN_ONLY :
                                                       sha512_pad_pkg::PAD_DATA;

  sha512_pad_logic i_pad_logic (
    .op             (pad_op),
    .bytes_in_block (len_q[BYTE_W-1:0]),
    .msg_len        (len_q),
    .block_in       (block_reg),
    .block_out      (pad_block),
    .need_extra     (need_extra)
  );

  // --------------------------------------------------
  // Next state and block push
  // --------------------------------------------------
  always_comb begin
    state_nxt     = state;
    out_push      = 1'b0;
    out_msg.data  = block_reg;
    out_msg.first = first_q;
    out_msg.last  = 1'b0;

    case (state)
      sha512_pad_pkg::ST_IDLE: begin
        // Empty message skips straight to padding
        if (msg_start) begin
          state_nxt = (msg_len == '0) ? sha512_pad_pkg::ST_PAD0 : sha512_pad_pkg::ST_FILL;
        end
      end
      sha512_pad_pkg::ST_FILL: begin
        if (block_full) begin
          // Full data block goes out as is, stall while the queue is full
          if (!out_full) begin
            out_push = 1'b1;
            if (words_left == '0) begin
              state_nxt = sha512_pad_pkg::ST_PAD0;
            end
          end
        end else if (last_pop && tail_bytes) begin
          state_nxt = sha512_pad_pkg::ST_PAD0;
        end
      end
      sha512_pad_pkg::ST_PAD0: begin
        out_msg.data = pad_block;
        out_msg.last = ~need_extra;
        if (!out_full) begin
          out_push  = 1'b1;
          state_nxt = need_extra ? sha512_pad_pkg::ST_PAD1 : sha512_pad_pkg::ST_IDLE;
        end
      end
      sha512_pad_pkg::ST_PAD1: begin
        out_msg.data  = pad_block;
        out_msg.first = 1'b0;
        out_msg.last  = 1'b1;
        if (!out_full) begin
          out_push  = 1'b1;
          state_nxt = sha512_pad_pkg::ST_IDLE;
        end
      end
      default: begin
        state_nxt = sha512_pad_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state      <= sha512_pad_pkg::ST_IDLE;
      len_q      <= '0;
      words_left <= '0;
      word_ptr   <= '0;
      first_q    <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == sha512_pad_pkg::ST_IDLE && msg_start) begin
        len_q      <= msg_len;
        words_left <= msg_words;
        word_ptr   <= '0;
        first_q    <= 1'b1;
      end else begin
        // Pop and push never coincide, pop needs a block that is not yet full
        if (word_pop) begin
          words_left <= words_left - 31'd1;
          word_ptr   <= word_ptr + 1'b1;
        end
        if (out_push) begin
          first_q  <= 1'b0;
          word_ptr <= '0;
        end
      end
    end
  end

  // Block storage, written at the word pointer
  always_ff @(posedge clk) begin
    if (word_pop) begin
      block_reg[word_ptr[PTR_W-1:0]] <= word_in;
    end
  end

endmodule

`default_nettype wire

//--- credit_tx.sv
// --------------------------------------------------
// Downstream credit counter and block output register
// The consumer must not grant more than 7 open credits
// --------------------------------------------------
`timescale 1ns/1ps
`include "sha512_pad_macros.svh"
`default_nettype none

module credit_tx (
  input  logic                     clk,
  input  logic                     rst_b,
  input  logic                     blk_credit,
  input  logic                     q_not_empty,
  input  sha512_pad_pkg::blk_msg_t q_data,
  output logic                     q_pop,
  output logic                     blk_valid,
  output sha512_pad_pkg::block_t   blk_data,
  output logic                     blk_first,
  output logic                     blk_last
);

  logic [`SHA_CREDIT_W-1:0] credit_cnt;

  // A queued block leaves only against a credit already held
  assign q_pop = q_not_empty & (credit_cnt != '0);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      credit_cnt <= '0;
      blk_valid  <= 1'b0;
    end else begin
      // Grant and send in one cycle leave the count unchanged
      case ({blk_credit, q_pop})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      blk_valid <= q_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (q_pop) begin
      blk_data  <= q_data.data;
      blk_first <= q_data.first;
      blk_last  <= q_data.last;
    end
  end

endmodule

`default_nettype wire

//--- sha512_pad_top.sv
// --------------------------------------------------
// SHA-512 block front end with credit flow on both sides
// Upstream holds 4 word credits after reset, downstream none
// --------------------------------------------------
`timescale 1ns/1ps
`include "sha512_pad_macros.svh"
`default_nettype none

module sha512_pad_top (
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic                   msg_start,
  input  logic [31:0]            msg_len,
  output logic                   busy,
  input  logic                   word_valid,
  input  sha512_pad_pkg::word_t  word_data,
  output logic                   word_credit,
  output logic                   blk_valid,
  output sha512_pad_pkg::block_t blk_data,
  output logic                   blk_first,
  output logic                   blk_last,
  input  logic                   blk_credit
);

  sha512_pad_pkg::word_t    word_q;
  sha512_pad_pkg::blk_msg_t out_msg;
  sha512_pad_pkg::blk_msg_t q_data;
  logic                     word_avail;
  logic                     word_pop;
  logic                     out_push;
  logic                     out_full;
  logic                     q_not_empty;
  logic                     q_pop;

  // Input words, credits go back upstream on each pop
  credit_fifo #(
    .payload_t (sha512_pad_pkg::word_t),
    .DEPTH     (`SHA_IN_DEPTH)
  ) i_word_fifo (
    .clk       (clk),
    .rst_b     (rst_b),
    .push      (word_valid),
    .push_data (word_data),
    .pop       (word_pop),
    .pop_data  (word_q),
    .not_empty (word_avail),
    .full      (),
    .credit    (word_credit)
  );

  sha512_block_builder i_builder (
    .clk        (clk),
    .rst_b      (rst_b),
    .msg_start  (msg_start),
    .msg_len    (msg_len),
    .busy       (busy),
    .word_avail (word_avail),
    .word_in    (word_q),
    .word_pop   (word_pop),
    .out_full   (out_full),
    .out_push   (out_push),
    .out_msg    (out_msg)
  );

  // Finished blocks wait here, the builder watches full
  credit_fifo #(
    .payload_t (sha512_pad_pkg::blk_msg_t),
    .DEPTH     (`SHA_OUT_DEPTH)
  ) i_blk_fifo (
    .clk       (clk),
    .rst_b     (rst_b),
    .push      (out_push),
    .push_data (out_msg),
    .pop       (q_pop),
    .pop_data  (q_data),
    .not_empty (q_not_empty),
    .full      (out_full),
    .credit    ()
  );

  credit_tx i_credit_tx (
    .clk         (clk),
    .rst_b       (rst_b),
    .blk_credit  (blk_credit),
    .q_not_empty (q_not_empty),
    .q_data      (q_data),
    .q_pop       (q_pop),
    .blk_valid   (blk_valid),
    .blk_data    (blk_data),
    .blk_first   (blk_first),
    .blk_last    (blk_last)
  );

endmodule

`default_nettype wire

//--- sha512_pad_assertions.sv
// --------------------------------------------------
// Credit checks for the block output, bound into credit_tx
// --------------------------------------------------
`timescale 1ns/1ps
`include "sha512_pad_macros.svh"
`default_nettype none

module sha512_pad_assertions (
  input logic                     clk,
  input logic                     rst_b,
  input logic                     blk_credit,
  input logic                     q_pop,
  input logic                     blk_valid,
  input logic [`SHA_CREDIT_W-1:0] credit_cnt
);

  // Grants seen on blk_credit less the blocks already sent on blk_valid
  logic [`SHA_CREDIT_W:0] open_grants;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      open_grants <= '0;
    end else begin
      case ({blk_credit, blk_valid})
        2'b10:   open_grants <= open_grants + 1'b1;
        2'b01:   open_grants <= open_grants - 1'b1;
        default: open_grants <= open_grants;
      endcase
    end
  end

  // A block may leave only against a grant from an earlier cycle
  credit_held: assert property (@(posedge clk) disable iff (!rst_b)
    blk_valid |-> open_grants != '0)
    else $error("blk_valid without a held credit");

  // A grant at the top count would wrap the counter
  credit_max: assert property (@(posedge clk) disable iff (!rst_b)
    (credit_cnt == {`SHA_CREDIT_W{1'b1}}) |-> !(blk_credit && !q_pop))
    else $error("credit counter overflow");

  reset_quiet: assert property (@(posedge clk) !rst_b |-> !blk_valid)
    else $error("blk_valid active during reset");

endmodule

bind credit_tx sha512_pad_assertions i_assertions (
  .clk        (clk),
  .rst_b      (rst_b),
  .blk_credit (blk_credit),
  .q_pop      (q_pop),
  .blk_valid  (blk_valid),
  .credit_cnt (credit_cnt)
);

`default_nettype wire

//--- tb_clkgen.sv
// --------------------------------------------------
// Free-running testbench clock and active-low reset
// Reset is released on a rising edge after RESET_CYCLES
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_b
);

  // 20 ns period with the default half period
  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst_b = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_b <= 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_sha512_pad.sv
// --------------------------------------------------
// Testbench for the SHA-512 block front end
// Messages are limited to 512 bytes by the byte store
// --------------------------------------------------
`timescale 1ns/1ps
`include "sha512_pad_macros.svh"
`default_nettype none

module tb_sha512_pad;

  localparam logic [31:0] SEED = 32'h3b9a_326f;

  logic                   clk;
  logic                   rst_b;
  logic                   busy;
  logic                   word_credit;
  logic                   blk_valid;
  logic                   blk_first;
  logic                   blk_last;
  sha512_pad_pkg::block_t blk_data;

  // DUT inputs start inactive at time zero
  logic                  msg_start  = 1'b0;
  logic [31:0]           msg_len    = '0;
  logic                  word_valid = 1'b0;
  sha512_pad_pkg::word_t word_data  = '0;
  logic                  blk_credit = 1'b0;

  sha512_pad_pkg::blk_msg_t exp_q [$];
  sha512_pad_pkg::blk_msg_t exp_msg;
  sha512_pad_pkg::word_t    word_q [$];
  logic [7:0]               msg_bytes [0:511];
  logic [31:0]              rng_data = SEED;
  logic [31:0]              rng_cred = SEED;
  logic                     hold_credits = 1'b0;
  int up_credits    = `SHA_IN_DEPTH;
  int credit_pulses = 0;
  int words_sent    = 0;
  int granted       = 0;
  int received      = 0;
  int errors        = 0;
  int diff_word;
  int i;

  tb_clkgen i_clkgen (
    .clk   (clk),
    .rst_b (rst_b)
  );

  sha512_pad_top i_dut (
    .clk         (clk),
    .rst_b       (rst_b),
    .msg_start   (msg_start),
    .msg_len     (msg_len),
    .busy        (busy),
    .word_valid  (word_valid),
    .word_data   (word_data),
    .word_credit (word_credit),
    .blk_valid   (blk_valid),
    .blk_data    (blk_data),
    .blk_first   (blk_first),
    .blk_last    (blk_last),
    .blk_credit  (blk_credit)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // 0x80 plus 16 length bytes follow the data, rounded up to whole blocks
  function automatic int ref_block_count(input int len);
    return (len + 1 + 16 + 127) / 128;
  endfunction

  // --------------------------------------------------
  // Reference padding, one block of the padded message
  // --------------------------------------------------
  function automatic sha512_pad_pkg::block_t ref_block(input int len, input int idx);
    sha512_pad_pkg::block_t blk;
    logic [127:0]           bit_len;
    logic [7:0]             byte_val;
    int                     n_blk;
    int                     pos;
    int                     b;
    n_blk   = ref_block_count(len);
    bit_len = {96'd0, 32'(len)} << 3;
    blk     = '0;
    for (b = 0; b < 128; b++) begin
      pos = idx * 128 + b;
      if (pos < len) begin
        byte_val = msg_bytes[pos];
      end else if (pos == len) begin
        byte_val = 8'h80;
      end else if (idx == n_blk - 1 && b >= 112) begin
        // Big-endian bit length fills the last 16 bytes of the final block
        byte_val = bit_len[8*(127-b) +: 8];
      end else begin
        byte_val = 8'h00;
      end
      blk[b/4][8*(3-b%4) +: 8] = byte_val;
    end
    return blk;
  endfunction

  // Upstream side, spends one credit per word and regains one per word_credit
  always @(posedge clk) begin
    if (rst_b) begin
      if (word_credit) begin
        up_credits++;
        credit_pulses++;
      end
      if (up_credits > 0 && word_q.size() > 0) begin
        word_valid <= 1'b1;
        word_data  <= word_q.pop_front();
        up_credits--;
        words_sent++;
      end else begin
        word_valid <= 1'b0;
      end
    end
  end

  // Consumer grants credits at random but only for blocks still expected
  always @(posedge clk) begin
    if (rst_b) begin
      rng_cred = xorshift32(rng_cred);
      if (!hold_credits && (granted - received) < 4 &&
          (granted - received) < exp_q.size() && rng_cred[1:0] != 2'b00) begin
        blk_credit <= 1'b1;
        granted++;
      end else begin
        blk_credit <= 1'b0;
      end
    end
  end

  // Compare every delivered block with the head of the expected list
  always @(negedge clk) begin
    if (rst_b && blk_valid) begin
      received++;
      if (exp_q.size() == 0) begin
        $display("Block delivered at %0t when none was expected", $time);
        errors++;
      end else begin
        exp_msg   = exp_q.pop_front();
        diff_word = -1;
        for (i = 31; i >= 0; i--) begin
          if (blk_data[i] !== exp_msg.data[i]) diff_word = i;
        end
        if (diff_word >= 0) begin
          $display("Mismatch at %0t: block %0d word %0d is %h, expected %h", $time,
                   received - 1, diff_word, blk_data[diff_word], exp_msg.data[diff_word]);
          errors++;
        end
        if (blk_first !== exp_msg.first || blk_last !== exp_msg.last) begin
          $display("Mismatch at %0t: block %0d first/last %b%b, expected %b%b", $time,
                   received - 1, blk_first, blk_last, exp_msg.first, exp_msg.last);
          errors++;
        end
      end
    end
  end

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (busy && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      $display("Timeout at %0t: busy never fell", $time);
      errors++;
    end
  endtask

  task automatic wait_blocks_done(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout at %0t: %0d expected blocks never arrived", $time, exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  // Random message bytes, expected blocks, queued words, then the command pulse
  task automatic start_message(input int len);
    sha512_pad_pkg::blk_msg_t m;
    int n_words;
    int n_blk;
    int k;
    n_words = (len + 3) / 4;
    n_blk   = ref_block_count(len);
    @(negedge clk);
    for (k = 0; k < n_words * 4; k++) begin
      rng_data     = xorshift32(rng_data);
      msg_bytes[k] = rng_data[7:0];
    end
    for (k = 0; k < n_blk; k++) begin
      m.data  = ref_block(len, k);
      m.first = (k == 0);
      m.last  = (k == n_blk - 1);
      exp_q.push_back(m);
    end
    for (k = 0; k < n_words; k++) begin
      word_q.push_back({msg_bytes[4*k], msg_bytes[4*k+1], msg_bytes[4*k+2], msg_bytes[4*k+3]});
    end
    @(posedge clk);
    msg_start <= 1'b1;
    msg_len   <= 32'(len);
    @(posedge clk);
    msg_start <= 1'b0;
  endtask

  task automatic run_message(input int len);
    wait_idle(500);
    start_message(len);
    wait_blocks_done(4000);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) $display("Test %s: ok", name);
    else $display("Test %s: %0d errors", name, errors - errs_before);
  endtask

  initial begin
    int errs0;
    int n;
    int pulses0;
    int sent0;
    int rx0;
    n = 0;
    while (!rst_b && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (!rst_b) begin
      $display("Reset was never released");
      errors++;
    end

    // Idle outputs, then short single-block messages
    errs0 = errors;
    for (n = 0; n < 10; n++) begin
      @(negedge clk);
      if (busy !== 1'b0 || blk_valid !== 1'b0 || word_credit !== 1'b0) begin
        $display("Mismatch at %0t: busy, blk_valid or word_credit active while idle", $time);
        errors++;
      end
    end
    run_message(0);
    run_message(3);
    run_message(55);
    report_test("1 reset and short messages", errs0);

    // Lengths around the extra pad block threshold
    errs0 = errors;
    run_message(111);
    run_message(112);
    run_message(127);
    run_message(128);
    report_test("2 pad boundaries", errs0);

    errs0 = errors;
    for (n = 0; n < 8; n++) begin
      rng_data = xorshift32(rng_data);
      run_message(int'(rng_data % 401));
    end
    report_test("3 random lengths", errs0);

    // Withheld credits stall the output and then the upstream
    errs0 = errors;
    wait_idle(500);
    hold_credits = 1'b1;
    rx0     = received;
    pulses0 = credit_pulses;
    sent0   = words_sent;
    start_message(480);
    repeat (300) @(negedge clk);
    if (received != rx0) begin
      $display("A block was delivered while no credit had been granted");
      errors++;
    end
    if (up_credits != 0 || word_q.size() == 0) begin
      $display("Upstream did not run out of credits during the stall");
      errors++;
    end
    hold_credits = 1'b0;
    wait_blocks_done(4000);
    wait_idle(500);
    if (credit_pulses - pulses0 != words_sent - sent0) begin
      $display("Mismatch at %0t: %0d word credits returned for %0d words", $time,
               credit_pulses - pulses0, words_sent - sent0);
      errors++;
    end
    report_test("4 back-pressure", errs0);

    // Second message starts while the first one's blocks are still queued
    errs0 = errors;
    wait_idle(500);
    hold_credits = 1'b1;
    start_message(200);
    wait_idle(500);
    start_message(70);
    @(negedge clk);
    hold_credits = 1'b0;
    wait_idle(2000);
    start_message(0);
    wait_blocks_done(4000);
    report_test("5 back-to-back messages", errs0);

    $display("Done: %0d blocks checked, %0d errors", received, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
sha512_pad_pkg.sv
credit_fifo.sv
sha512_pad_logic.sv
sha512_block_builder.sv
credit_tx.sv
sha512_pad_top.sv
sha512_pad_assertions.sv
tb_clkgen.sv
tb_sha512_pad.sv

//--- Makefile
TOP := tb_sha512_pad
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
